//--- hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

   ////////////////////////////////////////
   // widths and basic words
   ////////////////////////////////////////
   localparam int WORD_W = 32;   // data and address
   localparam int REG_AW = 5;    // 32 registers

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_AW-1:0] regidx_t;

   ////////////////////////////////////////
   // opcode and funct encodings
   ////////////////////////////////////////
   typedef enum logic [5:0] {
      RTYPE = 6'h00,    // decode by funct
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      SLTI  = 6'h0A,
      ANDI  = 6'h0C,    // zero extended
      ORI   = 6'h0D,    // zero extended
      LUI   = 6'h0F,
      LW    = 6'h23,
      SW    = 6'h2B,
      HALT  = 6'h3F     // stops the core
   } opcode_t;

   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_SLT  = 6'h2A   // signed compare
   } funct_t;

   // alu operations
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
   } alu_op_t;

   ////////////////////////////////////////
   // instruction formats
   ////////////////////////////////////////
   typedef struct packed {
      opcode_t    opcode;
      regidx_t    rs;
      regidx_t    rt;
      regidx_t    rd;
      logic [4:0] shamt;
      funct_t     funct;
   } instr_r_t;

   typedef struct packed {
      opcode_t     opcode;
      regidx_t     rs;
      regidx_t     rt;
      logic [15:0] imm16;   // offset or immediate
   } instr_i_t;

   // one fetched word, two views
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

endpackage

`default_nettype wire

//--- hdl/pipe_if.sv
`timescale 1ns/1ns
`default_nettype none

// fetch to decode
interface fd_if import mips_pkg::*; ();
   instr_u instr;    // raw fetched word
   word_t  pc4;      // pc + 4 of that word
   logic   valid;

   modport src (output instr, pc4, valid);
   modport dst (input  instr, pc4, valid);
endinterface

// decode to execute
interface dx_if import mips_pkg::*; ();
   logic       valid;
   alu_op_t    alu_op;
   logic       alu_imm;            // b operand is imm
   logic       shift;              // a operand is shamt
   logic       mem_rd, mem_wr;
   logic       reg_wr;
   logic       beq, bne;
   logic       halt;
   regidx_t    rs, rt, rd;         // rd is the destination, rt for i-type
   word_t      rdat1, rdat2;       // register file values
   word_t      imm;                // already extended
   logic [4:0] shamt;
   word_t      pc4;

   modport src (output valid, alu_op, alu_imm, shift, mem_rd, mem_wr, reg_wr,
                beq, bne, halt, rs, rt, rd, rdat1, rdat2, imm, shamt, pc4);
   modport dst (input  valid, alu_op, alu_imm, shift, mem_rd, mem_wr, reg_wr,
                beq, bne, halt, rs, rt, rd, rdat1, rdat2, imm, shamt, pc4);
endinterface

// execute to memory
interface xm_if import mips_pkg::*; ();
   logic    valid;
   word_t   alu_res;      // also the data address
   word_t   store_dat;
   regidx_t dest;
   logic    reg_wr, mem_rd, mem_wr, halt;

   modport src (output valid, alu_res, store_dat, dest, reg_wr, mem_rd, mem_wr, halt);
   modport dst (input  valid, alu_res, store_dat, dest, reg_wr, mem_rd, mem_wr, halt);
endinterface

// writeback, seen by decode and execute
interface wb_if import mips_pkg::*; ();
   logic    wen;
   regidx_t dest;
   word_t   wdat;
   logic    is_load;   // picks load data over alu result

   modport src (output wen, dest, wdat, is_load);
   modport dst (input  wen, dest, wdat, is_load);
endinterface

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import mips_pkg::*; (
   input  wire logic    CLK,
   input  wire logic    nRST,
   input  wire logic    wen_i,
   input  wire regidx_t wsel_i,
   input  wire regidx_t rsel1_i,
   input  wire regidx_t rsel2_i,
   input  wire word_t   wdat_i,
   output word_t        rdat1_o,
   output word_t        rdat2_o
);

   word_t regs [32];

   // r0 reads zero, same-cycle write bypasses
   function automatic word_t rd_port(input regidx_t sel);
      if (sel == '0) return '0;
      if (wen_i && wsel_i == sel) return wdat_i;
      return regs[sel];
   endfunction

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;
      end else if (wen_i && wsel_i != '0) begin
         regs[wsel_i] <= wdat_i;
      end
   end

   // also follows the write port and the array
   always_comb begin
      rdat1_o = rd_port(rsel1_i);
      rdat2_o = rd_port(rsel2_i);
   end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import mips_pkg::*; #(
   parameter word_t PC_INIT = '0
) (
   input  wire logic  CLK,
   input  wire logic  nRST,
   input  wire logic  advance_i,
   input  wire logic  hold_i,          // load-use stall
   input  wire logic  branch_taken_i,
   input  wire logic  halted_i,
   input  wire word_t branch_target_i,
   input  wire word_t imem_load_i,
   output word_t      imem_addr_o,
   output logic       imem_ren_o,
   fd_if.src          fd
);

   word_t pc;
   word_t pc4;

   assign pc4         = pc + 32'd4;
   assign imem_addr_o = pc;
   assign imem_ren_o  = !halted_i;   // no fetches after halt

   // next pc: branch target, hold, or sequential
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         pc <= PC_INIT;
      end else if (advance_i) begin
         if (branch_taken_i) pc <= branch_target_i;
         else if (!hold_i && !halted_i) pc <= pc4;
      end
   end

   ////////////////////////////////////////
   // IF/ID register
   ////////////////////////////////////////
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         fd.valid <= 1'b0;
      end else if (advance_i) begin
         if (branch_taken_i || halted_i) fd.valid <= 1'b0;   // bubble
         else if (!hold_i) fd.valid <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (advance_i && !hold_i) begin
         fd.instr <= imem_load_i;
         fd.pc4   <= pc4;
      end
   end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import mips_pkg::*; (
   input  wire logic CLK,
   input  wire logic nRST,
   input  wire logic advance_i,
   input  wire logic branch_taken_i,
   fd_if.dst         fd,
   wb_if.dst         wb,
   dx_if.src         dx,
   output logic      hold_o
);

   instr_u  ins;
   regidx_t rs, rt, dest;
   word_t   rdat1, rdat2, imm_ext;
   alu_op_t c_alu_op;
   logic    c_alu_imm, c_shift, c_mem_rd, c_mem_wr, c_reg_wr;
   logic    c_beq, c_bne, c_halt, c_zext, c_use_rd;

   assign ins = fd.instr;
   assign rs  = ins.i.rs;   // same bits in both views
   assign rt  = ins.i.rt;

   reg_file rf0 (
      .CLK     (CLK),
      .nRST    (nRST),
      .wen_i   (wb.wen && advance_i),   // write as MEM/WB retires
      .wsel_i  (wb.dest),
      .rsel1_i (rs),
      .rsel2_i (rt),
      .wdat_i  (wb.wdat),
      .rdat1_o (rdat1),
      .rdat2_o (rdat2)
   );

   ////////////////////////////////////////
   // control decode
   ////////////////////////////////////////
   always_comb begin
      c_alu_op  = ALU_ADD;
      c_alu_imm = 1'b0;
      c_shift   = 1'b0;
      c_mem_rd  = 1'b0;
      c_mem_wr  = 1'b0;
      c_reg_wr  = 1'b0;
      c_beq     = 1'b0;
      c_bne     = 1'b0;
      c_halt    = 1'b0;
      c_zext    = 1'b0;
      c_use_rd  = 1'b0;
      case (ins.r.opcode)
         RTYPE: begin
            c_reg_wr = 1'b1;
            c_use_rd = 1'b1;
            case (ins.r.funct)
               FN_ADDU: c_alu_op = ALU_ADD;
               FN_SUBU: c_alu_op = ALU_SUB;
               FN_AND:  c_alu_op = ALU_AND;
               FN_OR:   c_alu_op = ALU_OR;
               FN_XOR:  c_alu_op = ALU_XOR;
               FN_SLT:  c_alu_op = ALU_SLT;
               FN_SLL:  begin c_alu_op = ALU_SLL; c_shift = 1'b1; end
               FN_SRL:  begin c_alu_op = ALU_SRL; c_shift = 1'b1; end
               default: c_reg_wr = 1'b0;   // unknown funct acts as nop
            endcase
         end
         ADDIU: begin c_alu_imm = 1'b1; c_reg_wr = 1'b1; end
         SLTI:  begin c_alu_op = ALU_SLT; c_alu_imm = 1'b1; c_reg_wr = 1'b1; end
         ANDI:  begin c_alu_op = ALU_AND; c_alu_imm = 1'b1; c_reg_wr = 1'b1; c_zext = 1'b1; end
         ORI:   begin c_alu_op = ALU_OR;  c_alu_imm = 1'b1; c_reg_wr = 1'b1; c_zext = 1'b1; end
         LUI:   begin c_alu_op = ALU_LUI; c_alu_imm = 1'b1; c_reg_wr = 1'b1; end
         LW:    begin c_alu_imm = 1'b1; c_mem_rd = 1'b1; c_reg_wr = 1'b1; end
         SW:    begin c_alu_imm = 1'b1; c_mem_wr = 1'b1; end
         BEQ:   c_beq  = 1'b1;   // resolved in execute
         BNE:   c_bne  = 1'b1;
         HALT:  c_halt = 1'b1;
         default: ;              // nop
      endcase
   end

   assign dest    = c_use_rd ? ins.r.rd : ins.i.rt;
   assign imm_ext = c_zext ? {16'h0000, ins.i.imm16} : {{16{ins.i.imm16[15]}}, ins.i.imm16};

   // load in ID/EX feeding this instruction
   assign hold_o = fd.valid && dx.valid && dx.mem_rd && dx.rd != '0 &&
                   (dx.rd == rs || dx.rd == rt);

   ////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         dx.valid  <= 1'b0;
         dx.alu_op <= ALU_ADD;
         {dx.alu_imm, dx.shift, dx.mem_rd, dx.mem_wr} <= '0;
         {dx.reg_wr, dx.beq, dx.bne, dx.halt}         <= '0;
      end else if (advance_i) begin
         dx.valid   <= fd.valid && !hold_o && !branch_taken_i;   // bubble on stall or flush
         dx.alu_op  <= c_alu_op;
         dx.alu_imm <= c_alu_imm;
         dx.shift   <= c_shift;
         dx.mem_rd  <= c_mem_rd;
         dx.mem_wr  <= c_mem_wr;
         dx.reg_wr  <= c_reg_wr;
         dx.beq     <= c_beq;
         dx.bne     <= c_bne;
         dx.halt    <= c_halt;
      end
   end

   always_ff @(posedge CLK) begin
      if (advance_i) begin
         dx.rs    <= rs;
         dx.rt    <= rt;
         dx.rd    <= dest;
         dx.rdat1 <= rdat1;
         dx.rdat2 <= rdat2;
         dx.imm   <= imm_ext;
         dx.shamt <= ins.r.shamt;
         dx.pc4   <= fd.pc4;
      end
   end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import mips_pkg::*; (
   input  wire logic CLK,
   input  wire logic nRST,
   input  wire logic advance_i,
   dx_if.dst         dx,
   xm_if.src         xm,     // read back for forwarding
   wb_if.dst         wb,
   output logic      branch_taken_o,
   output word_t     branch_target_o
);

   word_t fwd_a, fwd_b;   // forwarded register values
   word_t op_a, op_b;     // alu inputs
   word_t alu_res;
   logic  ops_eq;

   ////////////////////////////////////////
   // forwarding
   ////////////////////////////////////////
   // EX/MEM wins over MEM/WB, never r0
   // loads in EX/MEM are excluded since load-use stalls first
   function automatic word_t fwd(input regidx_t idx, input word_t rdat);
      if (idx == '0) return rdat;
      if (xm.valid && xm.reg_wr && !xm.mem_rd && xm.dest == idx) return xm.alu_res;
      if (wb.wen && wb.dest == idx) return wb.wdat;
      return rdat;
   endfunction

   // follows EX/MEM and MEM/WB as well as ID/EX
   always_comb begin
      fwd_a = fwd(dx.rs, dx.rdat1);
      fwd_b = fwd(dx.rt, dx.rdat2);
   end

   assign op_a = dx.shift ? word_t'(dx.shamt) : fwd_a;   // shamt source
   assign op_b = dx.alu_imm ? dx.imm : fwd_b;            // immediate source

   ////////////////////////////////////////
   // alu
   ////////////////////////////////////////
   always_comb begin
      case (dx.alu_op)
         ALU_ADD: alu_res = op_a + op_b;
         ALU_SUB: alu_res = op_a - op_b;
         ALU_AND: alu_res = op_a & op_b;
         ALU_OR:  alu_res = op_a | op_b;
         ALU_XOR: alu_res = op_a ^ op_b;
         ALU_SLT: alu_res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         ALU_SLL: alu_res = op_b << op_a[4:0];   // value in rt
         ALU_SRL: alu_res = op_b >> op_a[4:0];
         ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
         default: alu_res = '0;
      endcase
   end

   // branches compare the forwarded registers directly
   assign ops_eq          = (fwd_a == fwd_b);
   assign branch_taken_o  = dx.valid && ((dx.beq && ops_eq) || (dx.bne && !ops_eq));
   assign branch_target_o = dx.pc4 + {dx.imm[29:0], 2'b00};

   ////////////////////////////////////////
   // EX/MEM register
   ////////////////////////////////////////
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         xm.valid  <= 1'b0;
         xm.reg_wr <= 1'b0;
         xm.mem_rd <= 1'b0;
         xm.mem_wr <= 1'b0;
         xm.halt   <= 1'b0;
      end else if (advance_i) begin
         xm.valid  <= dx.valid;
         xm.reg_wr <= dx.reg_wr;
         xm.mem_rd <= dx.mem_rd;
         xm.mem_wr <= dx.mem_wr;
         xm.halt   <= dx.halt;
      end
   end

   always_ff @(posedge CLK) begin
      if (advance_i) begin
         xm.alu_res   <= alu_res;
         xm.store_dat <= fwd_b;   // sw data from rt
         xm.dest      <= dx.rd;
      end
   end

endmodule

`default_nettype wire

//--- hdl/mem_wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage import mips_pkg::*; (
   input  wire logic  CLK,
   input  wire logic  nRST,
   input  wire logic  ihit_i,
   input  wire logic  dhit_i,
   input  wire word_t dmem_load_i,
   xm_if.dst          xm,
   wb_if.src          wb,
   output logic       advance_o,
   output logic       halted_o,
   output word_t      dmem_addr_o,
   output word_t      dmem_store_o,
   output logic       dmem_ren_o,
   output logic       dmem_wen_o
);

   logic    mwb_valid, mwb_reg_wr, mwb_load, mwb_halt;
   word_t   mwb_alu, mwb_ldat;
   regidx_t mwb_dest;
   logic    halt_seen, dreq;

   // younger instructions make no requests once halt hits writeback
   assign halt_seen = (mwb_valid && mwb_halt) || halted_o;
   assign dreq      = xm.valid && (xm.mem_rd || xm.mem_wr) && !halt_seen;

   assign dmem_addr_o  = xm.alu_res;
   assign dmem_store_o = xm.store_dat;
   assign dmem_ren_o   = dreq && xm.mem_rd;
   assign dmem_wen_o   = dreq && xm.mem_wr;   // held until dhit

   assign advance_o = ihit_i && (!dreq || dhit_i);   // one global stall

   ////////////////////////////////////////
   // MEM/WB register
   ////////////////////////////////////////
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         {mwb_valid, mwb_reg_wr, mwb_load, mwb_halt} <= '0;
      end else if (advance_o) begin
         mwb_valid  <= xm.valid;
         mwb_reg_wr <= xm.reg_wr;
         mwb_load   <= xm.mem_rd;
         mwb_halt   <= xm.halt;
      end
   end

   always_ff @(posedge CLK) begin
      if (advance_o) begin
         mwb_alu  <= xm.alu_res;
         mwb_ldat <= dmem_load_i;   // only meaningful for loads
         mwb_dest <= xm.dest;
      end
   end

   assign wb.wen     = mwb_valid && mwb_reg_wr;
   assign wb.dest    = mwb_dest;
   assign wb.is_load = mwb_load;
   assign wb.wdat    = wb.is_load ? mwb_ldat : mwb_alu;

   // sticky until reset
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) halted_o <= 1'b0;
      else if (mwb_valid && mwb_halt) halted_o <= 1'b1;
   end

endmodule

`default_nettype wire

//--- hdl/mips_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline import mips_pkg::*; #(
   parameter word_t PC_INIT = '0
) (
   input  wire logic  CLK,
   input  wire logic  nRST,
   input  wire logic  ihit_i,
   input  wire logic  dhit_i,
   input  wire word_t imem_load_i,
   input  wire word_t dmem_load_i,
   output word_t      imem_addr_o,
   output word_t      dmem_addr_o,
   output word_t      dmem_store_o,
   output logic       imem_ren_o,
   output logic       dmem_ren_o,
   output logic       dmem_wen_o,
   output logic       halt_o
);

   logic  advance;         // global pipeline step
   logic  hold;            // load-use
   logic  branch_taken;
   word_t branch_target;

   fd_if fd ();
   dx_if dx ();
   xm_if xm ();
   wb_if wb ();

   fetch_stage #(.PC_INIT(PC_INIT)) if0 (
      .CLK(CLK), .nRST(nRST),
      .advance_i(advance), .hold_i(hold),
      .branch_taken_i(branch_taken), .halted_i(halt_o),
      .branch_target_i(branch_target), .imem_load_i(imem_load_i),
      .imem_addr_o(imem_addr_o), .imem_ren_o(imem_ren_o),
      .fd(fd)
   );

   decode_stage id0 (
      .CLK(CLK), .nRST(nRST),
      .advance_i(advance), .branch_taken_i(branch_taken),
      .fd(fd), .wb(wb), .dx(dx), .hold_o(hold)
   );

   execute_stage ex0 (
      .CLK(CLK), .nRST(nRST), .advance_i(advance),
      .dx(dx), .xm(xm), .wb(wb),
      .branch_taken_o(branch_taken), .branch_target_o(branch_target)
   );

   mem_wb_stage mw0 (
      .CLK(CLK), .nRST(nRST),
      .ihit_i(ihit_i), .dhit_i(dhit_i), .dmem_load_i(dmem_load_i),
      .xm(xm), .wb(wb),
      .advance_o(advance), .halted_o(halt_o),
      .dmem_addr_o(dmem_addr_o), .dmem_store_o(dmem_store_o),
      .dmem_ren_o(dmem_ren_o), .dmem_wen_o(dmem_wen_o)
   );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
   parameter int PERIOD = 40   // ns
) (
   output logic CLK
);

   initial CLK = 1'b0;
   always #(PERIOD / 2) CLK = ~CLK;   // 50% duty

endmodule

`default_nettype wire

//--- tests/mips_props.sv
`timescale 1ns/1ns
`default_nettype none

module mips_props (
   input wire logic CLK,
   input wire logic nRST,
   input wire logic imem_ren_i,
   input wire logic dmem_ren_i,
   input wire logic dmem_wen_i,
   input wire logic halt_i
);

   // one data access at a time
   no_rd_wr: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_ren_i && dmem_wen_i))
      else $error("dmem read and write requested in the same cycle");

   // sticky halt
   halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt_i |=> halt_i)
      else $error("halt_o fell while nRST was high");

   no_fetch_halted: assert property (@(posedge CLK) disable iff (!nRST)
      halt_i |-> !imem_ren_i)
      else $error("instruction fetch requested after halt");

endmodule

bind mips_pipeline mips_props props0 (
   .CLK        (CLK),
   .nRST       (nRST),
   .imem_ren_i (imem_ren_o),
   .dmem_ren_i (dmem_ren_o),
   .dmem_wen_i (dmem_wen_o),
   .halt_i     (halt_o)
);

`default_nettype wire

//--- tests/tb_mips.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips import mips_pkg::*; ();

   localparam word_t PC_INIT    = 32'h0000_0040;
   localparam int    HALT_LIMIT = 2000;   // cycles per program

   logic  CLK, nRST;
   logic  ihit_i, dhit_i;
   word_t imem_load_i, dmem_load_i;
   word_t imem_addr_o, dmem_addr_o, dmem_store_o;
   logic  imem_ren_o, dmem_ren_o, dmem_wen_o, halt_o;

   word_t imem [256];
   word_t dmem [256];
   word_t dexp [256];   // expected data memory
   word_t prog [$];     // program under construction
   word_t lfsr;
   logic  waits_on;     // random hit levels
   string cur_test;
   int    checks, errors, test_c0, test_e0;
   bit    timed_out;

   tb_clock #(.PERIOD(40)) clk0 (.CLK(CLK));

   mips_pipeline #(.PC_INIT(PC_INIT)) dut0 (.*);

   ////////////////////////////////////////
   // memory models
   ////////////////////////////////////////
   function automatic word_t lfsr_next(input word_t s);
      if (s[0]) return (s >> 1) ^ 32'h8020_0003;   // x^32+x^22+x^2+x+1
      return s >> 1;
   endfunction

   function automatic word_t fill_word(input int idx);
      return {8'hD0 ^ idx[7:0], idx[7:0], ~idx[7:0], 8'h3C ^ idx[7:0]};
   endfunction

   // inputs change 2 ns after the rising edge
   always begin
      @(posedge CLK);
      #2;
      if (waits_on) begin
         lfsr   = lfsr_next(lfsr);
         ihit_i = lfsr[0];
         lfsr   = lfsr_next(lfsr);
         dhit_i = lfsr[0];
      end else begin
         ihit_i = 1'b1;
         dhit_i = 1'b1;
      end
      imem_load_i = imem[imem_addr_o[9:2]];
      dmem_load_i = dmem_ren_o ? dmem[dmem_addr_o[9:2]] : 'x;   // data only on a read
   end

   // store lands when the pipeline advances
   always @(negedge CLK) begin
      if (nRST && dmem_wen_o && dhit_i && ihit_i) dmem[dmem_addr_o[9:2]] = dmem_store_o;
   end

   ////////////////////////////////////////
   // assembler helpers
   ////////////////////////////////////////
   function automatic word_t asm_r(funct_t fn, int rd, int rs, int rt, int sh);
      return {RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
   endfunction

   function automatic word_t asm_i(opcode_t op, int rt, int rs, int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   task automatic emit(input word_t w);
      prog.push_back(w);
   endtask

   task automatic expect_store(input word_t addr, input word_t val);
      dexp[addr[9:2]] = val;
   endtask

   ////////////////////////////////////////
   // checking and sequencing
   ////////////////////////////////////////
   task automatic check(input string what, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      prog.delete();
      for (int i = 0; i < 256; i++) dexp[i] = fill_word(i);
      test_c0 = checks;
      test_e0 = errors;
   endtask

   task automatic end_test;
      $display("%s: %0d checks, %0d errors", cur_test, checks - test_c0, errors - test_e0);
   endtask

   task automatic apply_reset;
      @(posedge CLK);
      #2 nRST = 1'b0;
      repeat (5) @(posedge CLK);
      #2 nRST = 1'b1;
   endtask

   // load program and data, then reset
   task automatic prepare(input bit waits);
      waits_on = waits;
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;   // sll r0 acts as nop
         dmem[i] = fill_word(i);
      end
      foreach (prog[k]) imem[PC_INIT[9:2] + k] = prog[k];
      apply_reset;
   endtask

   task automatic wait_halt;
      int n;
      n = 0;
      while (!halt_o && n < HALT_LIMIT) begin
         @(negedge CLK);
         n++;
      end
      if (!halt_o) begin
         $display("%s: halt_o did not rise within %0d cycles", cur_test, HALT_LIMIT);
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic compare_dmem;
      for (int i = 0; i < 256; i++) check($sformatf("dmem[%h]", i * 4), dexp[i], dmem[i]);
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic test_reset;
      begin_test("reset");
      emit({HALT, 26'h0});
      prepare(1'b0);
      #1;   // still before the first edge out of reset
      check("imem_addr_o", PC_INIT, imem_addr_o);
      check("imem_ren_o", 32'd1, word_t'(imem_ren_o));
      check("halt_o", 32'd0, word_t'(halt_o));
      check("dmem_ren_o", 32'd0, word_t'(dmem_ren_o));
      check("dmem_wen_o", 32'd0, word_t'(dmem_wen_o));
      wait_halt;
      if (!timed_out) compare_dmem;
      end_test;
   endtask

   // dependent alu chain, each result stored at 0x80 + 4*reg
   task automatic test_alu(input string name, input bit waits);
      word_t e [14];
      int    rr [12] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 11, 12, 13};
      begin_test(name);
      e[1]  = 32'h0000_1234;
      e[2]  = {16'h8765, 16'h0000} | 32'h0000_4321;   // ori zero extends
      e[3]  = e[1] + e[2];
      e[4]  = e[3] - e[1];
      e[5]  = ($signed(e[2]) < $signed(e[1])) ? 32'd1 : 32'd0;
      e[6]  = ($signed(e[4]) < $signed(32'hFFFF_8000)) ? 32'd1 : 32'd0;
      e[7]  = e[4] ^ e[6];
      e[8]  = e[7] << 4;
      e[9]  = e[8] >> 7;
      e[11] = e[9] & 32'h0000_F0F0;
      e[12] = e[11] & e[2];
      e[13] = e[12] | e[5];
      emit(asm_i(ADDIU, 1, 0, 'h1234));
      emit(asm_i(LUI, 2, 0, 'h8765));
      emit(asm_i(ORI, 2, 2, 'h4321));         // from EX/MEM
      emit(asm_r(FN_ADDU, 3, 1, 2, 0));
      emit(asm_r(FN_SUBU, 4, 3, 1, 0));
      emit(asm_r(FN_SLT, 5, 2, 1, 0));
      emit(asm_i(SLTI, 6, 4, 'h8000));        // sign extended
      emit(asm_r(FN_XOR, 7, 4, 6, 0));        // both forwarded
      emit(asm_r(FN_SLL, 8, 0, 7, 4));
      emit(asm_r(FN_SRL, 9, 0, 8, 7));
      emit(asm_i(ANDI, 11, 9, 'hF0F0));
      emit(asm_r(FN_AND, 12, 11, 2, 0));
      emit(asm_r(FN_OR, 13, 12, 5, 0));
      emit(asm_i(ADDIU, 10, 0, 'h80));        // store base
      foreach (rr[k]) begin
         emit(asm_i(SW, rr[k], 10, 4 * rr[k]));
         expect_store(32'h80 + 4 * rr[k], e[rr[k]]);
      end
      emit({HALT, 26'h0});
      prepare(waits);
      wait_halt;
      if (!timed_out) begin
         compare_dmem;
         if (waits) begin
            for (int i = 0; i < 20; i++) begin
               @(negedge CLK);
               check($sformatf("imem_ren_o %0d after halt", i), 32'd0, word_t'(imem_ren_o));
            end
         end
      end
      end_test;
   endtask

   task automatic test_load_use;
      begin_test("load_use");
      emit(asm_i(ADDIU, 10, 0, 'h40));
      emit(asm_i(ADDIU, 2, 0, 'h0123));
      emit(asm_i(LW, 1, 10, 'h08));
      emit(asm_r(FN_ADDU, 3, 1, 2, 0));       // stalls one cycle
      emit(asm_i(SW, 3, 10, 'h0C));
      emit(asm_i(LW, 4, 10, 'h10));
      emit(asm_i(SW, 4, 10, 'h14));           // store data from the load
      emit({HALT, 26'h0});
      expect_store(32'h4C, fill_word(32'h48 >> 2) + 32'h0123);
      expect_store(32'h54, fill_word(32'h50 >> 2));
      prepare(1'b0);
      wait_halt;
      if (!timed_out) compare_dmem;
      end_test;
   endtask

   // each branch skips two stores when taken
   task automatic test_branch;
      begin_test("branch");
      emit(asm_i(ADDIU, 10, 0, 'hC0));
      emit(asm_i(ADDIU, 1, 0, 5));
      emit(asm_i(ADDIU, 2, 0, 5));
      emit(asm_i(ADDIU, 3, 0, 7));
      emit(asm_i(BEQ, 2, 1, 2));              // taken
      emit(asm_i(SW, 3, 10, 'h00));
      emit(asm_i(SW, 3, 10, 'h04));
      emit(asm_i(SW, 1, 10, 'h08));
      emit(asm_i(BEQ, 3, 1, 2));              // not taken
      emit(asm_i(SW, 1, 10, 'h0C));
      emit(asm_i(SW, 2, 10, 'h10));
      emit(asm_i(BNE, 3, 1, 2));              // taken
      emit(asm_i(SW, 3, 10, 'h14));
      emit(asm_i(SW, 3, 10, 'h18));
      emit(asm_i(SW, 3, 10, 'h1C));
      emit({HALT, 26'h0});
      expect_store(32'hC8, 32'd5);
      expect_store(32'hCC, 32'd5);
      expect_store(32'hD0, 32'd5);
      expect_store(32'hDC, 32'd7);
      prepare(1'b0);
      wait_halt;
      if (!timed_out) compare_dmem;
      end_test;
   endtask

   initial begin
      nRST        = 1'b0;
      ihit_i      = 1'b1;
      dhit_i      = 1'b1;
      imem_load_i = '0;
      dmem_load_i = '0;
      lfsr        = 32'h9707;
      waits_on    = 1'b0;
      checks      = 0;
      errors      = 0;
      timed_out   = 1'b0;
      test_reset;
      if (!timed_out) test_alu("alu_forward", 1'b0);
      if (!timed_out) test_load_use;
      if (!timed_out) test_branch;
      if (!timed_out) test_alu("wait_states", 1'b1);
      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- mips_core.f
hdl/mips_pkg.sv
hdl/pipe_if.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/mips_pipeline.sv
tests/tb_clock.sv
tests/mips_props.sv
tests/tb_mips.sv
